// ==== Bender.yml ====
package:
  name: cce

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cce_pkg.sv
      - rtl/cce_ucode_fetch.sv
      - rtl/cce_inst_decode.sv
      - rtl/cce_src_sel.sv
      - rtl/cce_alu.sv
      - rtl/cce_regs.sv
      - rtl/cce_msg.sv
      - rtl/cce_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - sim/cce_tb.sv

// ==== all.f ====
+incdir+rtl
rtl/cce_pkg.sv
rtl/cce_ucode_fetch.sv
rtl/cce_inst_decode.sv
rtl/cce_src_sel.sv
rtl/cce_alu.sv
rtl/cce_regs.sv
rtl/cce_msg.sv
rtl/cce_top.sv
sim/cce_tb.sv

// ==== rtl/cce_alu.sv ====
//################################################
// ALU and branch compare
//################################################
`timescale 1ns/1ns
`include "cce_defines.svh"

module cce_alu (
  input  logic                 alu_v_i,
  input  cce_pkg::cce_alu_op_e alu_op_i,
  input  logic                 br_v_i,
  input  cce_pkg::cce_br_op_e  br_op_i,
  input  cce_pkg::cce_gpr_t    opd_a_i,
  input  cce_pkg::cce_gpr_t    opd_b_i,
  output cce_pkg::cce_gpr_t    res_o,
  output logic                 branch_taken_o
);
  import cce_pkg::*;

  cce_gpr_t res;
  logic     cond;

  always_comb begin
    case (alu_op_i)
      e_alu_add: res = opd_a_i + opd_b_i;
      e_alu_sub: res = opd_a_i - opd_b_i;
      e_alu_and: res = opd_a_i & opd_b_i;
      e_alu_or:  res = opd_a_i | opd_b_i;
      e_alu_xor: res = opd_a_i ^ opd_b_i;
      default:   res = '0;
    endcase
    // Unsigned compare
    case (br_op_i)
      e_br_eq:     cond = (opd_a_i == opd_b_i);
      e_br_ne:     cond = (opd_a_i != opd_b_i);
      e_br_lt:     cond = (opd_a_i < opd_b_i);
      e_br_always: cond = 1'b1;
      default:     cond = 1'b0;
    endcase
  end

  assign res_o          = alu_v_i ? res : '0;
  assign branch_taken_o = br_v_i & cond;

endmodule

// ==== rtl/cce_defines.svh ====
//################################################
// Coherence engine widths and sizes
//################################################
`ifndef CCE_DEFINES_SVH
`define CCE_DEFINES_SVH

// Microcode store
`define CCE_INST_W 32
`define CCE_PC_W 6
`define CCE_IMM_W 14

// Datapath and register file
`define CCE_GPR_W 16
`define CCE_NUM_GPR 8
`define CCE_GPR_SEL_W 3

// LCE side
`define CCE_LCE_W 2
`define CCE_ADDR_W 16
`define CCE_BLOCK_OFFSET_W 3
`define CCE_WG_W 4
// Way group sits right above the block offset
`define CCE_WG_LSB `CCE_BLOCK_OFFSET_W
`define CCE_NUM_WG (1 << `CCE_WG_W)

`endif

// ==== rtl/cce_inst_decode.sv ====
//################################################
// Instruction decoder
// Opcode picks the view, one strobe class out
//################################################
`timescale 1ns/1ns
`include "cce_defines.svh"

module cce_inst_decode (
  input  cce_pkg::cce_inst_u        inst_i,
  input  logic                      inst_v_i,
  output logic                      alu_v_o,
  output cce_pkg::cce_alu_op_e      alu_op_o,
  output logic                      br_v_o,
  output cce_pkg::cce_br_op_e       br_op_o,
  output logic [`CCE_PC_W-1:0]      branch_target_o,
  output cce_pkg::cce_src_e         src_a_o,
  output cce_pkg::cce_src_e         src_b_o,
  output cce_pkg::cce_gpr_t         imm_o,
  output logic                      gpr_w_v_o,
  output logic [`CCE_GPR_SEL_W-1:0] gpr_dst_o,
  output logic                      wdp_v_o,
  output logic                      pend_val_o,
  output logic                      pop_req_o,
  output logic                      send_cmd_o
);
  import cce_pkg::*;

  cce_op_e op;

  // Opcode sits at the top of both formats
  assign op = inst_i.alu.op;

  always_comb begin
    alu_v_o         = 1'b0;
    alu_op_o        = inst_i.alu.minor;
    br_v_o          = 1'b0;
    br_op_o         = inst_i.br.minor;
    branch_target_o = inst_i.br.target;
    src_a_o         = inst_i.alu.src_a;
    src_b_o         = inst_i.alu.src_b;
    imm_o           = cce_gpr_t'(inst_i.alu.imm);
    gpr_w_v_o       = 1'b0;
    gpr_dst_o       = inst_i.alu.dst;
    wdp_v_o         = 1'b0;
    pend_val_o      = inst_i.alu.imm[0];
    pop_req_o       = 1'b0;
    send_cmd_o      = 1'b0;
    if (inst_v_i) begin
      case (op)
        e_op_alu: begin
          alu_v_o   = 1'b1;
          gpr_w_v_o = 1'b1;
        end
        e_op_movi: begin
          // imm | imm
          alu_v_o   = 1'b1;
          alu_op_o  = e_alu_or;
          src_a_o   = e_src_imm;
          src_b_o   = e_src_imm;
          gpr_w_v_o = 1'b1;
        end
        e_op_branch: begin
          br_v_o  = 1'b1;
          src_a_o = inst_i.br.src_a;
          src_b_o = inst_i.br.src_b;
        end
        e_op_wdp: begin
          wdp_v_o = 1'b1;
        end
        e_op_pop_req: begin
          pop_req_o = 1'b1;
        end
        e_op_send_cmd: begin
          send_cmd_o = 1'b1;
        end
        default: begin
          alu_v_o = 1'b0;
        end
      endcase
    end
  end

endmodule

// ==== rtl/cce_msg.sv ====
//################################################
// Message unit
// LCE request pop and LCE command send
//################################################
`timescale 1ns/1ns
`include "cce_defines.svh"

module cce_msg (
  input  logic                   pop_req_i,
  input  logic                   send_cmd_i,
  input  logic                   lce_req_v_i,
  input  logic                   lce_cmd_ready_i,
  input  cce_pkg::cce_gpr_t      opd_a_i,
  input  logic [`CCE_LCE_W-1:0]  req_lce_i,
  input  logic [`CCE_ADDR_W-1:0] req_addr_i,
  output logic                   stall_o,
  output logic                   req_capture_o,
  output logic                   lce_req_yumi_o,
  output logic                   lce_cmd_v_o,
  output logic [`CCE_LCE_W-1:0]  lce_cmd_lce_o,
  output logic [`CCE_ADDR_W-1:0] lce_cmd_addr_o,
  output cce_pkg::cce_gpr_t      lce_cmd_data_o
);

  logic req_pop;
  logic cmd_send;

  // Inbound valid->yumi, outbound ready&valid
  assign req_pop  = pop_req_i & lce_req_v_i;
  assign cmd_send = send_cmd_i & lce_cmd_ready_i;

  // Hold the instruction until its channel can move
  assign stall_o = (pop_req_i & ~lce_req_v_i) | (send_cmd_i & ~lce_cmd_ready_i);

  assign lce_req_yumi_o = req_pop;
  assign req_capture_o  = req_pop;
  assign lce_cmd_v_o    = cmd_send;
  assign lce_cmd_lce_o  = req_lce_i;
  assign lce_cmd_addr_o = req_addr_i;
  assign lce_cmd_data_o = opd_a_i;

endmodule

// ==== rtl/cce_pkg.sv ====
//################################################
// Coherence engine types
// Opcodes, operand selects and instruction formats
//################################################
`include "cce_defines.svh"

package cce_pkg;

  typedef enum logic [3:0] {
    e_op_alu      = 4'd0,
    e_op_movi     = 4'd1,
    e_op_branch   = 4'd2,
    e_op_wdp      = 4'd3,
    e_op_pop_req  = 4'd4,
    e_op_send_cmd = 4'd5
  } cce_op_e;

  typedef enum logic [2:0] {
    e_alu_add = 3'd0,
    e_alu_sub = 3'd1,
    e_alu_and = 3'd2,
    e_alu_or  = 3'd3,
    e_alu_xor = 3'd4
  } cce_alu_op_e;

  typedef enum logic [2:0] {
    e_br_eq     = 3'd0,
    e_br_ne     = 3'd1,
    e_br_lt     = 3'd2,
    e_br_always = 3'd3
  } cce_br_op_e;

  typedef enum logic [3:0] {
    e_src_r0        = 4'd0,
    e_src_r1        = 4'd1,
    e_src_r2        = 4'd2,
    e_src_r3        = 4'd3,
    e_src_r4        = 4'd4,
    e_src_r5        = 4'd5,
    e_src_r6        = 4'd6,
    e_src_r7        = 4'd7,
    e_src_imm       = 4'd8,
    e_src_req_lce   = 4'd9,
    e_src_req_addr  = 4'd10,
    e_src_lce_req_v = 4'd11,
    e_src_req_pend  = 4'd12,
    e_src_num_wg    = 4'd13
  } cce_src_e;

  typedef logic [`CCE_GPR_W-1:0] cce_gpr_t;

  // ALU, movi, wdp, pop and send
  typedef struct packed {
    cce_op_e                   op;
    cce_alu_op_e               minor;
    logic [`CCE_GPR_SEL_W-1:0] dst;
    cce_src_e                  src_a;
    cce_src_e                  src_b;
    logic [`CCE_IMM_W-1:0]     imm;
  } cce_inst_alu_s;

  typedef struct packed {
    cce_op_e              op;
    cce_br_op_e           minor;
    cce_src_e             src_a;
    cce_src_e             src_b;
    logic [`CCE_PC_W-1:0] target;
    logic [10:0]          pad;
  } cce_inst_br_s;

  typedef union packed {
    cce_inst_alu_s alu;
    cce_inst_br_s  br;
  } cce_inst_u;

endpackage

// ==== rtl/cce_regs.sv ====
//################################################
// GPR file, request register, pending bits
// All written at retirement
//################################################
`timescale 1ns/1ns
`include "cce_defines.svh"

module cce_regs (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 stall_i,
  input  logic                                 gpr_w_v_i,
  input  logic [`CCE_GPR_SEL_W-1:0]            gpr_dst_i,
  input  cce_pkg::cce_gpr_t                    res_i,
  input  logic                                 wdp_v_i,
  input  logic [`CCE_WG_W-1:0]                 wdp_wg_i,
  input  logic                                 pend_val_i,
  input  logic                                 req_capture_i,
  input  logic [`CCE_LCE_W-1:0]                lce_req_lce_i,
  input  logic [`CCE_ADDR_W-1:0]               lce_req_addr_i,
  output cce_pkg::cce_gpr_t [`CCE_NUM_GPR-1:0] gpr_o,
  output logic [`CCE_LCE_W-1:0]                req_lce_o,
  output logic [`CCE_ADDR_W-1:0]               req_addr_o,
  output logic                                 req_pending_o
);
  import cce_pkg::*;

  cce_gpr_t [`CCE_NUM_GPR-1:0] gpr_q;
  logic [`CCE_LCE_W-1:0]       req_lce_q;
  logic [`CCE_ADDR_W-1:0]      req_addr_q;
  logic [`CCE_NUM_WG-1:0]      pend_q;
  logic [`CCE_WG_W-1:0]        req_wg;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpr_q <= '0;
    end else if (!stall_i && gpr_w_v_i) begin
      gpr_q[gpr_dst_i] <= res_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_lce_q  <= '0;
      req_addr_q <= '0;
    end else if (!stall_i && req_capture_i) begin
      req_lce_q  <= lce_req_lce_i;
      req_addr_q <= lce_req_addr_i;
    end
  end

  // One bit per way group
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q <= '0;
    end else if (!stall_i && wdp_v_i) begin
      pend_q[wdp_wg_i] <= pend_val_i;
    end
  end

  assign req_wg        = req_addr_q[`CCE_WG_LSB +: `CCE_WG_W];
  assign req_pending_o = pend_q[req_wg];
  assign gpr_o         = gpr_q;
  assign req_lce_o     = req_lce_q;
  assign req_addr_o    = req_addr_q;

endmodule

// ==== rtl/cce_src_sel.sv ====
//################################################
// Operand A/B source select
//################################################
`timescale 1ns/1ns
`include "cce_defines.svh"

module cce_src_sel (
  input  cce_pkg::cce_src_e                    src_a_i,
  input  cce_pkg::cce_src_e                    src_b_i,
  input  cce_pkg::cce_gpr_t                    imm_i,
  input  cce_pkg::cce_gpr_t [`CCE_NUM_GPR-1:0] gpr_i,
  input  logic [`CCE_LCE_W-1:0]                req_lce_i,
  input  logic [`CCE_ADDR_W-1:0]               req_addr_i,
  input  logic                                 lce_req_v_i,
  input  logic                                 req_pending_i,
  output cce_pkg::cce_gpr_t                    opd_a_o,
  output cce_pkg::cce_gpr_t                    opd_b_o
);
  import cce_pkg::*;

  // Narrow sources land zero-extended
  function automatic cce_gpr_t sel_src(input cce_src_e src);
    cce_gpr_t opd;
    opd = '0;
    case (src)
      e_src_r0, e_src_r1, e_src_r2, e_src_r3,
      e_src_r4, e_src_r5, e_src_r6, e_src_r7: begin
        opd = gpr_i[src[`CCE_GPR_SEL_W-1:0]];
      end
      e_src_imm: begin
        opd = imm_i;
      end
      e_src_req_lce: begin
        opd[`CCE_LCE_W-1:0] = req_lce_i;
      end
      e_src_req_addr: begin
        opd[`CCE_ADDR_W-1:0] = req_addr_i;
      end
      e_src_lce_req_v: begin
        opd[0] = lce_req_v_i;
      end
      e_src_req_pend: begin
        opd[0] = req_pending_i;
      end
      e_src_num_wg: begin
        opd = cce_gpr_t'(`CCE_NUM_WG);
      end
      default: begin
        opd = '0;
      end
    endcase
    return opd;
  endfunction

  always_comb begin
    opd_a_o = sel_src(src_a_i);
    opd_b_o = sel_src(src_b_i);
  end

endmodule

// ==== rtl/cce_top.sv ====
//################################################
// Microcoded coherence engine top level
//################################################
`timescale 1ns/1ns
`include "cce_defines.svh"

module cce_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cfg_run_i,
  input  logic                   cfg_ucode_w_v_i,
  input  logic [`CCE_PC_W-1:0]   cfg_ucode_addr_i,
  input  logic [`CCE_INST_W-1:0] cfg_ucode_data_i,
  output logic [`CCE_INST_W-1:0] cfg_ucode_data_o,
  input  logic                   lce_req_v_i,
  input  logic [`CCE_LCE_W-1:0]  lce_req_lce_i,
  input  logic [`CCE_ADDR_W-1:0] lce_req_addr_i,
  output logic                   lce_req_yumi_o,
  input  logic                   lce_cmd_ready_i,
  output logic                   lce_cmd_v_o,
  output logic [`CCE_LCE_W-1:0]  lce_cmd_lce_o,
  output logic [`CCE_ADDR_W-1:0] lce_cmd_addr_o,
  output cce_pkg::cce_gpr_t      lce_cmd_data_o
);
  import cce_pkg::*;

  cce_inst_u                   inst;
  logic                        inst_v;
  logic                        stall;
  logic                        branch_taken;
  logic [`CCE_PC_W-1:0]        branch_target;
  logic                        alu_v;
  cce_alu_op_e                 alu_op;
  logic                        br_v;
  cce_br_op_e                  br_op;
  cce_src_e                    src_a;
  cce_src_e                    src_b;
  cce_gpr_t                    imm;
  logic                        gpr_w_v;
  logic [`CCE_GPR_SEL_W-1:0]   gpr_dst;
  logic                        wdp_v;
  logic                        pend_val;
  logic                        pop_req;
  logic                        send_cmd;
  logic                        req_capture;
  cce_gpr_t [`CCE_NUM_GPR-1:0] gpr;
  logic [`CCE_LCE_W-1:0]       req_lce;
  logic [`CCE_ADDR_W-1:0]      req_addr;
  logic                        req_pending;
  cce_gpr_t                    opd_a;
  cce_gpr_t                    opd_b;
  cce_gpr_t                    res;

  cce_ucode_fetch fetch (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cfg_run_i(cfg_run_i),
    .cfg_ucode_w_v_i(cfg_ucode_w_v_i), .cfg_ucode_addr_i(cfg_ucode_addr_i),
    .cfg_ucode_data_i(cfg_ucode_data_i), .cfg_ucode_data_o(cfg_ucode_data_o),
    .stall_i(stall), .branch_taken_i(branch_taken), .branch_target_i(branch_target),
    .inst_o(inst), .inst_v_o(inst_v)
  );

  cce_inst_decode decode (
    .inst_i(inst), .inst_v_i(inst_v),
    .alu_v_o(alu_v), .alu_op_o(alu_op), .br_v_o(br_v), .br_op_o(br_op),
    .branch_target_o(branch_target), .src_a_o(src_a), .src_b_o(src_b), .imm_o(imm),
    .gpr_w_v_o(gpr_w_v), .gpr_dst_o(gpr_dst), .wdp_v_o(wdp_v), .pend_val_o(pend_val),
    .pop_req_o(pop_req), .send_cmd_o(send_cmd)
  );

  cce_src_sel src_sel (
    .src_a_i(src_a), .src_b_i(src_b), .imm_i(imm), .gpr_i(gpr),
    .req_lce_i(req_lce), .req_addr_i(req_addr), .lce_req_v_i(lce_req_v_i),
    .req_pending_i(req_pending), .opd_a_o(opd_a), .opd_b_o(opd_b)
  );

  cce_alu alu (
    .alu_v_i(alu_v), .alu_op_i(alu_op), .br_v_i(br_v), .br_op_i(br_op),
    .opd_a_i(opd_a), .opd_b_i(opd_b), .res_o(res), .branch_taken_o(branch_taken)
  );

  // Way group for wdp comes from operand A
  cce_regs regs (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .stall_i(stall),
    .gpr_w_v_i(gpr_w_v), .gpr_dst_i(gpr_dst), .res_i(res),
    .wdp_v_i(wdp_v), .wdp_wg_i(opd_a[`CCE_WG_W-1:0]), .pend_val_i(pend_val),
    .req_capture_i(req_capture), .lce_req_lce_i(lce_req_lce_i),
    .lce_req_addr_i(lce_req_addr_i), .gpr_o(gpr), .req_lce_o(req_lce),
    .req_addr_o(req_addr), .req_pending_o(req_pending)
  );

  cce_msg msg (
    .pop_req_i(pop_req), .send_cmd_i(send_cmd), .lce_req_v_i(lce_req_v_i),
    .lce_cmd_ready_i(lce_cmd_ready_i), .opd_a_i(opd_a),
    .req_lce_i(req_lce), .req_addr_i(req_addr), .stall_o(stall),
    .req_capture_o(req_capture), .lce_req_yumi_o(lce_req_yumi_o),
    .lce_cmd_v_o(lce_cmd_v_o), .lce_cmd_lce_o(lce_cmd_lce_o),
    .lce_cmd_addr_o(lce_cmd_addr_o), .lce_cmd_data_o(lce_cmd_data_o)
  );

endmodule

// ==== rtl/cce_ucode_fetch.sv ====
//################################################
// Microcode RAM with config load and readback
// PC sequencing, stall hold and branch redirect
//################################################
`timescale 1ns/1ns
`include "cce_defines.svh"

module cce_ucode_fetch (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cfg_run_i,
  input  logic                   cfg_ucode_w_v_i,
  input  logic [`CCE_PC_W-1:0]   cfg_ucode_addr_i,
  input  logic [`CCE_INST_W-1:0] cfg_ucode_data_i,
  output logic [`CCE_INST_W-1:0] cfg_ucode_data_o,
  input  logic                   stall_i,
  input  logic                   branch_taken_i,
  input  logic [`CCE_PC_W-1:0]   branch_target_i,
  output cce_pkg::cce_inst_u     inst_o,
  output logic                   inst_v_o
);

  logic [`CCE_INST_W-1:0] ucode_mem [2**`CCE_PC_W];
  logic [`CCE_INST_W-1:0] rd_q;
  logic [`CCE_PC_W-1:0]   fetch_pc_q;
  logic                   inst_v_q;
  logic [`CCE_PC_W-1:0]   rd_addr;
  logic                   rd_en;

  // Config port owns the read port in load mode
  assign rd_addr = cfg_run_i ? fetch_pc_q : cfg_ucode_addr_i;
  // Held word is the stalled instruction
  assign rd_en   = ~cfg_run_i | ~stall_i;

  always_ff @(posedge clk_i) begin
    if (!cfg_run_i && cfg_ucode_w_v_i) begin
      ucode_mem[cfg_ucode_addr_i] <= cfg_ucode_data_i;
    end
    if (rd_en) begin
      rd_q <= ucode_mem[rd_addr];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetch_pc_q <= '0;
      inst_v_q   <= 1'b0;
    end else if (!cfg_run_i) begin
      fetch_pc_q <= '0;
      inst_v_q   <= 1'b0;
    end else if (!stall_i) begin
      fetch_pc_q <= branch_taken_i ? branch_target_i : fetch_pc_q + 1'b1;
      // Sequential word read beside a taken branch is dropped
      inst_v_q   <= ~branch_taken_i;
    end
  end

  assign inst_o           = rd_q;
  assign inst_v_o         = inst_v_q & cfg_run_i;
  assign cfg_ucode_data_o = rd_q;

endmodule

// ==== sim/cce_tb.sv ====
//################################################
// Coherence engine testbench
// Loads microcode, drives LCE traffic and checks
// the command stream against a reference model
//################################################
`timescale 1ns/1ns
`include "cce_defines.svh"

module cce_tb;
  import cce_pkg::*;

  localparam int NUM_REQ = 12;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   cfg_run_i;
  logic                   cfg_ucode_w_v_i;
  logic [`CCE_PC_W-1:0]   cfg_ucode_addr_i;
  logic [`CCE_INST_W-1:0] cfg_ucode_data_i;
  logic [`CCE_INST_W-1:0] cfg_ucode_data_o;
  logic                   lce_req_v_i;
  logic [`CCE_LCE_W-1:0]  lce_req_lce_i;
  logic [`CCE_ADDR_W-1:0] lce_req_addr_i;
  logic                   lce_req_yumi_o;
  logic                   lce_cmd_ready_i;
  logic                   lce_cmd_v_o;
  logic [`CCE_LCE_W-1:0]  lce_cmd_lce_o;
  logic [`CCE_ADDR_W-1:0] lce_cmd_addr_o;
  cce_gpr_t               lce_cmd_data_o;

  integer seed = 32'h4635_91a8;
  int     error_count = 0;
  int     tests_run = 0;
  int     tests_bad = 0;
  int     cmd_done = 0;
  bit     rand_mode = 0;
  bit     req_taken = 0;

  cce_inst_u              prog [2**`CCE_PC_W];
  logic [`CCE_LCE_W-1:0]  req_lce_a [NUM_REQ];
  logic [`CCE_ADDR_W-1:0] req_addr_a [NUM_REQ];
  int                     req_n = 0;
  int                     drv_idx = 0;

  // Model state persists across tests like the DUT
  cce_gpr_t               model_gpr [`CCE_NUM_GPR];
  logic                   model_pend [`CCE_NUM_WG];
  logic [`CCE_LCE_W-1:0]  model_req_lce;
  logic [`CCE_ADDR_W-1:0] model_req_addr;

  logic [`CCE_LCE_W-1:0]  exp_lce [$];
  logic [`CCE_ADDR_W-1:0] exp_addr [$];
  cce_gpr_t               exp_data [$];
  logic [`CCE_LCE_W-1:0]  got_lce [$];
  logic [`CCE_ADDR_W-1:0] got_addr [$];
  cce_gpr_t               got_data [$];

  cce_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Reset and readback, then per test the load, the run limit and the drain
  initial begin
    int budget;
    budget = 10 + 64 * 3 + 6 * 40;
    budget = budget + 2 * (14 + 6 * 20) + (6 + 5 * 20);
    budget = budget + 2 * (4 + 8 * 20) + (4 + 12 * 20);
    repeat (budget) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the engine stopped making progress", budget);
    $display("test failed");
    $finish;
  end

  function automatic cce_inst_u asm_alu(cce_op_e op, cce_alu_op_e minor, int dst,
                                        cce_src_e src_a, cce_src_e src_b, int imm);
    cce_inst_u w;
    w.alu.op    = op;
    w.alu.minor = minor;
    w.alu.dst   = dst[`CCE_GPR_SEL_W-1:0];
    w.alu.src_a = src_a;
    w.alu.src_b = src_b;
    w.alu.imm   = imm[`CCE_IMM_W-1:0];
    return w;
  endfunction

  function automatic cce_inst_u asm_br(cce_br_op_e minor, cce_src_e src_a, cce_src_e src_b,
                                       int target);
    cce_inst_u w;
    w.br.op     = e_op_branch;
    w.br.minor  = minor;
    w.br.src_a  = src_a;
    w.br.src_b  = src_b;
    w.br.target = target[`CCE_PC_W-1:0];
    w.br.pad    = '0;
    return w;
  endfunction

  function automatic cce_inst_u asm_movi(int dst, int imm);
    return asm_alu(e_op_movi, e_alu_or, dst, e_src_imm, e_src_imm, imm);
  endfunction

  function automatic cce_inst_u asm_send(cce_src_e src);
    return asm_alu(e_op_send_cmd, e_alu_add, 0, src, e_src_r0, 0);
  endfunction

  function automatic cce_gpr_t model_src(cce_src_e src, cce_inst_u w, int ri);
    case (src)
      e_src_imm:       return cce_gpr_t'(w.alu.imm);
      e_src_req_lce:   return cce_gpr_t'(model_req_lce);
      e_src_req_addr:  return cce_gpr_t'(model_req_addr);
      e_src_lce_req_v: return cce_gpr_t'(ri < req_n);
      e_src_req_pend:  return cce_gpr_t'(model_pend[model_req_addr[`CCE_WG_LSB +: `CCE_WG_W]]);
      e_src_num_wg:    return cce_gpr_t'(`CCE_NUM_WG);
      default:         return (src < e_src_imm) ? model_gpr[src[2:0]] : '0;
    endcase
  endfunction

  // Walks the program until it halts on a self branch or runs out of requests
  function automatic int cce_ref_cmd();
    int        pc;
    int        ri;
    int        cnt;
    cce_inst_u w;
    cce_gpr_t  a;
    cce_gpr_t  b;
    logic      taken;
    pc  = 0;
    ri  = 0;
    cnt = 0;
    for (int steps = 0; steps < 1000; steps++) begin
      w = prog[pc];
      if (w.alu.op == e_op_branch) begin
        a = model_src(w.br.src_a, w, ri);
        b = model_src(w.br.src_b, w, ri);
        case (w.br.minor)
          e_br_eq:  taken = (a == b);
          e_br_ne:  taken = (a != b);
          e_br_lt:  taken = (a < b);
          default:  taken = 1'b1;
        endcase
        if (w.br.minor == e_br_always && w.br.target == pc) return cnt;
        pc = taken ? int'(w.br.target) : (pc + 1) % 64;
        continue;
      end
      a = model_src(w.alu.src_a, w, ri);
      b = model_src(w.alu.src_b, w, ri);
      case (w.alu.op)
        e_op_alu: begin
          case (w.alu.minor)
            e_alu_add: model_gpr[w.alu.dst] = a + b;
            e_alu_sub: model_gpr[w.alu.dst] = a - b;
            e_alu_and: model_gpr[w.alu.dst] = a & b;
            e_alu_or:  model_gpr[w.alu.dst] = a | b;
            e_alu_xor: model_gpr[w.alu.dst] = a ^ b;
            default:   model_gpr[w.alu.dst] = '0;
          endcase
        end
        e_op_movi: model_gpr[w.alu.dst] = cce_gpr_t'(w.alu.imm);
        e_op_wdp:  model_pend[a[`CCE_WG_W-1:0]] = w.alu.imm[0];
        e_op_pop_req: begin
          if (ri >= req_n) return cnt;
          model_req_lce  = req_lce_a[ri];
          model_req_addr = req_addr_a[ri];
          ri++;
        end
        e_op_send_cmd: begin
          exp_lce.push_back(model_req_lce);
          exp_addr.push_back(model_req_addr);
          exp_data.push_back(a);
          cnt++;
        end
        default: ;
      endcase
      pc = (pc + 1) % 64;
    end
    return cnt;
  endfunction

  task automatic check_word(input cce_inst_u got, input cce_inst_u exp, input int addr);
    if (got !== exp) begin
      $display("[ERROR] %0t: ucode word %0d read %h, expected %h", $time, addr, got, exp);
      error_count++;
    end
  endtask

  task automatic check_cmd(input logic [`CCE_LCE_W-1:0] got_l, input logic [`CCE_LCE_W-1:0] exp_l,
                           input logic [`CCE_ADDR_W-1:0] got_a,
                           input logic [`CCE_ADDR_W-1:0] exp_a,
                           input cce_gpr_t got_d, input cce_gpr_t exp_d);
    if (got_l !== exp_l || got_a !== exp_a || got_d !== exp_d) begin
      $display("[ERROR] %0t: command lce %0d addr %h data %h, expected lce %0d addr %h data %h",
               $time, got_l, got_a, got_d, exp_l, exp_a, exp_d);
      error_count++;
    end
  endtask

  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  // Handshakes sampled mid-cycle away from the edges
  initial begin
    forever begin
      @(negedge clk_i);
      req_taken = lce_req_yumi_o;
      if (lce_req_yumi_o && !lce_req_v_i) begin
        $display("[ERROR] %0t: yumi raised without a valid request", $time);
        error_count++;
      end
      if (lce_cmd_v_o) begin
        if (!lce_cmd_ready_i) begin
          $display("[ERROR] %0t: command valid while ready is low", $time);
          error_count++;
        end
        got_lce.push_back(lce_cmd_lce_o);
        got_addr.push_back(lce_cmd_addr_o);
        got_data.push_back(lce_cmd_data_o);
      end
    end
  end

  initial begin
    forever begin
      @(posedge clk_i);
      while (got_data.size() > 0) begin
        if (exp_data.size() == 0) begin
          $display("[ERROR] %0t: unexpected command with data %h", $time, got_data[0]);
          error_count++;
        end else begin
          check_cmd(got_lce[0], exp_lce.pop_front(), got_addr[0], exp_addr.pop_front(),
                    got_data[0], exp_data.pop_front());
        end
        void'(got_lce.pop_front());
        void'(got_addr.pop_front());
        void'(got_data.pop_front());
        cmd_done++;
      end
    end
  end

  // Request source and command back-pressure
  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      if (req_taken) drv_idx++;
      lce_cmd_ready_i = rand_mode ? 1'($random(seed)) : 1'b1;
      lce_req_v_i     = (drv_idx < req_n) && (rand_mode ? 1'($random(seed)) : 1'b1);
      lce_req_lce_i   = req_lce_a[drv_idx % NUM_REQ];
      lce_req_addr_i  = req_addr_a[drv_idx % NUM_REQ];
    end
  end

  task automatic load_prog(input int len);
    for (int i = 0; i < len; i++) begin
      cfg_ucode_w_v_i  = 1'b1;
      cfg_ucode_addr_i = i[`CCE_PC_W-1:0];
      cfg_ucode_data_i = prog[i];
      tick();
    end
    cfg_ucode_w_v_i = 1'b0;
  endtask

  task automatic run_test(input string name, input int len, input bit rnd);
    int errs0;
    int exp_n;
    int cycles;
    errs0     = error_count;
    rand_mode = rnd;
    load_prog(len);
    exp_lce.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_n    = cce_ref_cmd();
    cmd_done = 0;
    drv_idx  = 0;
    cfg_run_i = 1'b1;
    cycles = 0;
    while (cmd_done < exp_n && cycles < len + exp_n * 20) begin
      tick();
      cycles++;
    end
    if (cmd_done < exp_n) begin
      $display("Only %0d of %0d commands arrived in %s", cmd_done, exp_n, name);
      error_count++;
    end
    repeat (20) tick();
    cfg_run_i = 1'b0;
    tick();
    tests_run++;
    if (error_count == errs0) begin
      $display("%s: ok, %0d commands", name, exp_n);
    end else begin
      $display("%s: mismatch", name);
      tests_bad++;
    end
  endtask

  task automatic readback_test();
    int errs0;
    errs0 = error_count;
    for (int i = 0; i < 64; i++) prog[i] = $random(seed) ^ (i << 26);
    load_prog(64);
    for (int i = 0; i < 64; i++) begin
      cfg_ucode_addr_i = i[`CCE_PC_W-1:0];
      tick();
      check_word(cfg_ucode_data_o, prog[i], i);
    end
    tests_run++;
    if (error_count == errs0) begin
      $display("readback: ok");
    end else begin
      $display("readback: mismatch");
      tests_bad++;
    end
  endtask

  task automatic alu_prog();
    prog[0]  = asm_movi(1, $random(seed));
    prog[1]  = asm_movi(2, $random(seed));
    prog[2]  = asm_send(e_src_r1);
    prog[3]  = asm_alu(e_op_alu, e_alu_add, 3, e_src_r1, e_src_r2, 0);
    prog[4]  = asm_send(e_src_r3);
    prog[5]  = asm_alu(e_op_alu, e_alu_sub, 3, e_src_r1, e_src_r2, 0);
    prog[6]  = asm_send(e_src_r3);
    prog[7]  = asm_alu(e_op_alu, e_alu_and, 3, e_src_r1, e_src_imm, $random(seed));
    prog[8]  = asm_send(e_src_r3);
    prog[9]  = asm_alu(e_op_alu, e_alu_or, 3, e_src_r2, e_src_imm, $random(seed));
    prog[10] = asm_send(e_src_r3);
    prog[11] = asm_alu(e_op_alu, e_alu_xor, 3, e_src_r3, e_src_r1, 0);
    prog[12] = asm_send(e_src_r3);
    prog[13] = asm_br(e_br_always, e_src_r0, e_src_r0, 13);
    req_n = 0;
  endtask

  // Pop, send with address plus a constant, loop
  task automatic req_prog();
    prog[0] = asm_alu(e_op_pop_req, e_alu_add, 0, e_src_r0, e_src_r0, 0);
    prog[1] = asm_alu(e_op_alu, e_alu_add, 1, e_src_req_addr, e_src_imm, 16'h0123);
    prog[2] = asm_send(e_src_r1);
    prog[3] = asm_br(e_br_always, e_src_r0, e_src_r0, 0);
    req_n = 8;
    for (int i = 0; i < req_n; i++) begin
      req_lce_a[i]  = $random(seed);
      req_addr_a[i] = $random(seed);
    end
  endtask

  initial begin
    logic [3:0] wg;
    rst_n_i          = 1'b0;
    cfg_run_i        = 1'b0;
    cfg_ucode_w_v_i  = 1'b0;
    cfg_ucode_addr_i = '0;
    cfg_ucode_data_i = '0;
    lce_req_v_i      = 1'b0;
    lce_req_lce_i    = '0;
    lce_req_addr_i   = '0;
    lce_cmd_ready_i  = 1'b1;
    for (int i = 0; i < `CCE_NUM_GPR; i++) model_gpr[i] = '0;
    for (int i = 0; i < `CCE_NUM_WG; i++) model_pend[i] = 1'b0;
    model_req_lce  = '0;
    model_req_addr = '0;
    repeat (10) tick();
    rst_n_i = 1'b1;
    tick();

    readback_test();
    alu_prog();
    run_test("alu ops", 14, 1'b0);

    // Countdown from 5 with r0 as the zero reference
    prog[0] = asm_movi(0, 0);
    prog[1] = asm_movi(2, 5);
    prog[2] = asm_send(e_src_r2);
    prog[3] = asm_alu(e_op_alu, e_alu_sub, 2, e_src_r2, e_src_imm, 1);
    prog[4] = asm_br(e_br_ne, e_src_r2, e_src_r0, 2);
    prog[5] = asm_br(e_br_always, e_src_r0, e_src_r0, 5);
    req_n = 0;
    run_test("countdown loop", 6, 1'b0);

    req_prog();
    run_test("request echo", 4, 1'b0);

    // Addresses chosen so the low nibble equals the way group
    prog[0] = asm_alu(e_op_pop_req, e_alu_add, 0, e_src_r0, e_src_r0, 0);
    prog[1] = asm_send(e_src_req_pend);
    prog[2] = asm_alu(e_op_wdp, e_alu_add, 0, e_src_req_addr, e_src_r0, 1);
    prog[3] = asm_br(e_br_always, e_src_r0, e_src_r0, 0);
    req_n = NUM_REQ;
    for (int i = 0; i < req_n; i++) begin
      wg            = 4'($random(seed) & 3);
      wg[3]         = wg[0];
      req_lce_a[i]  = $random(seed);
      req_addr_a[i] = {9'($random(seed)), wg[3:1], wg[0], wg[2:0]};
    end
    run_test("pending table", 4, 1'b0);

    alu_prog();
    run_test("alu ops under back-pressure", 14, 1'b1);
    req_prog();
    run_test("request echo under back-pressure", 4, 1'b1);

    $display("tests %0d, failing %0d, errors %0d", tests_run, tests_bad, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
